// ==== src/vmux_pkg.sv ====
// Shared types for the in-order result multiplexer
// Execution unit and opcode enums, opcode-to-unit mapping

`default_nettype none

package vmux_pkg;

    // Execution units behind the dispatcher
    typedef enum logic {
        UNIT_ALU = 1'b0,
        UNIT_MUL = 1'b1
    } op_unit_e;

    typedef enum logic [2:0] {
        OP_ADD   = 3'd0,
        OP_SUB   = 3'd1,
        OP_AND   = 3'd2,
        OP_XOR   = 3'd3,
        OP_MUL   = 3'd4,
        OP_MULHU = 3'd5
    } op_e;

    // Both multiply flavours go to the iterative unit
    function automatic op_unit_e unit_of_op(op_e op);
        case (op)
            OP_MUL, OP_MULHU: return UNIT_MUL;
            default:          return UNIT_ALU;
        endcase
    endfunction

endpackage

`default_nettype wire

// ==== src/unit_if.sv ====
// Request and result channels between the dispatcher and one execution unit

`default_nettype none

interface unit_if #(
    parameter int unsigned DATA_W = 32,
    parameter int unsigned ID_W   = 3
);
    import vmux_pkg::*;

    // Request channel
    logic              req_valid;
    logic              req_ready;
    logic [ID_W-1:0]   req_id;
    op_e               req_op;
    logic [DATA_W-1:0] req_a;
    logic [DATA_W-1:0] req_b;

    // Result channel
    logic              res_valid;
    logic              res_ready;
    logic [ID_W-1:0]   res_id;
    logic [DATA_W-1:0] res_data;

    modport dispatch (
        output req_valid, req_id, req_op, req_a, req_b, res_ready,
        input  req_ready, res_valid, res_id, res_data
    );

    modport unit (
        input  req_valid, req_id, req_op, req_a, req_b, res_ready,
        output req_ready, res_valid, res_id, res_data
    );

endinterface

`default_nettype wire

// ==== src/unit_order_queue.sv ====
// Order queue: FIFO of the unit that owns each instruction in flight
// Registered full and empty flags

`default_nettype none

module unit_order_queue #(
    parameter int unsigned QUEUE_DEPTH = 4
) (
    input  logic               clk_i,
    input  logic               arst_n_i,
    input  logic               enq_i,
    input  vmux_pkg::op_unit_e enq_unit_i,
    input  logic               deq_i,
    output vmux_pkg::op_unit_e head_unit_o,
    output logic               empty_o,
    output logic               full_o
);
    import vmux_pkg::*;

    localparam int unsigned PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(QUEUE_DEPTH + 1);

    op_unit_e         mem_q [QUEUE_DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic [CNT_W-1:0] count_d;

    // Wrap for depths that are not a power of two
    function automatic logic [PTR_W-1:0] next_ptr(logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : ptr + PTR_W'(1);
    endfunction

    always_comb begin
        count_d = count_q;
        if (enq_i && !deq_i) begin
            count_d = count_q + CNT_W'(1);
        end else if (deq_i && !enq_i) begin
            count_d = count_q - CNT_W'(1);
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            empty_o  <= 1'b1;
            full_o   <= 1'b0;
        end else begin
            if (enq_i) wr_ptr_q <= next_ptr(wr_ptr_q);
            if (deq_i) rd_ptr_q <= next_ptr(rd_ptr_q);
            count_q <= count_d;
            empty_o <= (count_d == '0);
            full_o  <= (count_d == CNT_W'(QUEUE_DEPTH));
        end
    end

    always_ff @(posedge clk_i) begin
        if (enq_i) mem_q[wr_ptr_q] <= enq_unit_i;
    end

    assign head_unit_o = mem_q[rd_ptr_q];

endmodule

`default_nettype wire

// ==== src/unit_dispatch.sv ====
// Dispatcher: steers requests to a unit, tracks issue order,
// and returns results in that order

`default_nettype none

module unit_dispatch #(
    parameter int unsigned DATA_W      = 32,
    parameter int unsigned ID_W        = 3,
    parameter int unsigned QUEUE_DEPTH = 4
) (
    input  logic              clk_i,
    input  logic              arst_n_i,
    input  logic              in_valid_i,
    output logic              in_ready_o,
    input  logic [ID_W-1:0]   in_id_i,
    input  vmux_pkg::op_e     in_op_i,
    input  logic [DATA_W-1:0] in_a_i,
    input  logic [DATA_W-1:0] in_b_i,
    unit_if.dispatch          alu_if,
    unit_if.dispatch          mul_if,
    output logic              out_valid_o,
    input  logic              out_ready_i,
    output logic [ID_W-1:0]   out_id_o,
    output logic [DATA_W-1:0] out_result_o
);
    import vmux_pkg::*;

    op_unit_e tgt_unit;
    op_unit_e head_unit;
    logic     q_empty;
    logic     q_full;
    logic     enq;
    logic     deq;

    // ------------------------------------------------------------------------
    // Issue side
    // ------------------------------------------------------------------------
    assign tgt_unit = unit_of_op(in_op_i);

    assign alu_if.req_valid = in_valid_i && !q_full && (tgt_unit == UNIT_ALU);
    assign mul_if.req_valid = in_valid_i && !q_full && (tgt_unit == UNIT_MUL);
    assign in_ready_o = !q_full &&
                        ((tgt_unit == UNIT_ALU) ? alu_if.req_ready : mul_if.req_ready);
    assign enq = in_valid_i && in_ready_o;

    // Payload fans out, only the selected unit sees valid
    assign alu_if.req_id = in_id_i;
    assign alu_if.req_op = in_op_i;
    assign alu_if.req_a  = in_a_i;
    assign alu_if.req_b  = in_b_i;
    assign mul_if.req_id = in_id_i;
    assign mul_if.req_op = in_op_i;
    assign mul_if.req_a  = in_a_i;
    assign mul_if.req_b  = in_b_i;

    unit_order_queue #(
        .QUEUE_DEPTH ( QUEUE_DEPTH )
    ) order_queue_i (
        .clk_i       ( clk_i       ),
        .arst_n_i    ( arst_n_i    ),
        .enq_i       ( enq         ),
        .enq_unit_i  ( tgt_unit    ),
        .deq_i       ( deq         ),
        .head_unit_o ( head_unit   ),
        .empty_o     ( q_empty     ),
        .full_o      ( q_full      )
    );

    // ------------------------------------------------------------------------
    // Result side, only the head unit may deliver
    // ------------------------------------------------------------------------
    always_comb begin
        out_valid_o  = 1'b0;
        out_id_o     = alu_if.res_id;
        out_result_o = alu_if.res_data;
        if (head_unit == UNIT_MUL) begin
            out_id_o     = mul_if.res_id;
            out_result_o = mul_if.res_data;
        end
        if (!q_empty) begin
            out_valid_o = (head_unit == UNIT_MUL) ? mul_if.res_valid : alu_if.res_valid;
        end
    end

    assign alu_if.res_ready = out_ready_i && !q_empty && (head_unit == UNIT_ALU);
    assign mul_if.res_ready = out_ready_i && !q_empty && (head_unit == UNIT_MUL);
    assign deq = out_valid_o && out_ready_i;

endmodule

`default_nettype wire

// ==== src/alu_unit.sv ====
// Single-cycle ALU: add, sub, and, xor into a one-entry result register

`default_nettype none

module alu_unit #(
    parameter int unsigned DATA_W = 32,
    parameter int unsigned ID_W   = 3
) (
    input  logic clk_i,
    input  logic arst_n_i,
    unit_if.unit port
);
    import vmux_pkg::*;

    logic              res_valid_q;
    logic [ID_W-1:0]   res_id_q;
    logic [DATA_W-1:0] res_data_q;
    logic [DATA_W-1:0] result;
    logic              accept;

    // Accept while empty or while the held result drains
    assign port.req_ready = !res_valid_q || port.res_ready;
    assign accept         = port.req_valid && port.req_ready;

    always_comb begin
        case (port.req_op)
            OP_ADD:  result = port.req_a + port.req_b;
            OP_SUB:  result = port.req_a - port.req_b;
            OP_AND:  result = port.req_a & port.req_b;
            OP_XOR:  result = port.req_a ^ port.req_b;
            default: result = '0;
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            res_valid_q <= 1'b0;
        end else if (accept) begin
            res_valid_q <= 1'b1;
        end else if (port.res_ready) begin
            res_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            res_id_q   <= port.req_id;
            res_data_q <= result;
        end
    end

    assign port.res_valid = res_valid_q;
    assign port.res_id    = res_id_q;
    assign port.res_data  = res_data_q;

endmodule

`default_nettype wire

// ==== src/mul_unit.sv ====
// Iterative shift-add multiplier, one product bit per cycle
// Low or high half of the unsigned product, held in a result register

`default_nettype none

module mul_unit #(
    parameter int unsigned DATA_W = 32,
    parameter int unsigned ID_W   = 3
) (
    input  logic clk_i,
    input  logic arst_n_i,
    unit_if.unit port
);
    import vmux_pkg::*;

    localparam int unsigned CNT_W = (DATA_W > 1) ? $clog2(DATA_W) : 1;

    typedef enum logic [1:0] {
        MUL_IDLE,
        MUL_CALC,
        MUL_PACK,
        MUL_DONE
    } mul_state_e;

    mul_state_e          state_q;
    logic [CNT_W-1:0]    cnt_q;
    logic [DATA_W-1:0]   a_q;
    logic [2*DATA_W-1:0] prod_q;
    logic [ID_W-1:0]     id_q;
    op_e                 op_q;
    logic [DATA_W-1:0]   res_data_q;
    logic [DATA_W:0]     partial;
    logic                accept;

    assign port.req_ready = (state_q == MUL_IDLE);
    assign accept         = port.req_valid && (state_q == MUL_IDLE);

    // Upper half plus multiplicand when the current multiplier bit is set
    assign partial = {1'b0, prod_q[2*DATA_W-1:DATA_W]} + (prod_q[0] ? {1'b0, a_q} : '0);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= MUL_IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                MUL_IDLE: if (accept) begin
                    state_q <= MUL_CALC;
                    cnt_q   <= '0;
                end
                MUL_CALC: begin
                    cnt_q <= cnt_q + CNT_W'(1);
                    if (cnt_q == CNT_W'(DATA_W - 1)) state_q <= MUL_PACK;
                end
                MUL_PACK: state_q <= MUL_DONE;
                MUL_DONE: if (port.res_ready) state_q <= MUL_IDLE;
                default:  state_q <= MUL_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            a_q    <= port.req_a;
            prod_q <= {{DATA_W{1'b0}}, port.req_b};
            id_q   <= port.req_id;
            op_q   <= port.req_op;
        end else if (state_q == MUL_CALC) begin
            prod_q <= {partial, prod_q[DATA_W-1:1]};
        end
        if (state_q == MUL_PACK) begin
            res_data_q <= (op_q == OP_MULHU) ? prod_q[2*DATA_W-1:DATA_W] : prod_q[DATA_W-1:0];
        end
    end

    assign port.res_valid = (state_q == MUL_DONE);
    assign port.res_id    = id_q;
    assign port.res_data  = res_data_q;

endmodule

`default_nettype wire

// ==== src/unit_mux_top.sv ====
// Top level: dispatcher, ALU and multiplier with their unit buses

`default_nettype none

module unit_mux_top #(
    parameter int unsigned DATA_W      = 32,
    parameter int unsigned ID_W        = 3,
    parameter int unsigned QUEUE_DEPTH = 4
) (
    input  logic              clk_i,
    input  logic              arst_n_i,
    input  logic              in_valid_i,
    output logic              in_ready_o,
    input  logic [ID_W-1:0]   in_id_i,
    input  vmux_pkg::op_e     in_op_i,
    input  logic [DATA_W-1:0] in_a_i,
    input  logic [DATA_W-1:0] in_b_i,
    output logic              out_valid_o,
    input  logic              out_ready_i,
    output logic [ID_W-1:0]   out_id_o,
    output logic [DATA_W-1:0] out_result_o
);

    unit_if #(.DATA_W(DATA_W), .ID_W(ID_W)) alu_bus ();
    unit_if #(.DATA_W(DATA_W), .ID_W(ID_W)) mul_bus ();

    unit_dispatch #(
        .DATA_W       ( DATA_W       ),
        .ID_W         ( ID_W         ),
        .QUEUE_DEPTH  ( QUEUE_DEPTH  )
    ) dispatch_i (
        .clk_i        ( clk_i        ),
        .arst_n_i     ( arst_n_i     ),
        .in_valid_i   ( in_valid_i   ),
        .in_ready_o   ( in_ready_o   ),
        .in_id_i      ( in_id_i      ),
        .in_op_i      ( in_op_i      ),
        .in_a_i       ( in_a_i       ),
        .in_b_i       ( in_b_i       ),
        .alu_if       ( alu_bus      ),
        .mul_if       ( mul_bus      ),
        .out_valid_o  ( out_valid_o  ),
        .out_ready_i  ( out_ready_i  ),
        .out_id_o     ( out_id_o     ),
        .out_result_o ( out_result_o )
    );

    alu_unit #(
        .DATA_W   ( DATA_W   ),
        .ID_W     ( ID_W     )
    ) alu_i (
        .clk_i    ( clk_i    ),
        .arst_n_i ( arst_n_i ),
        .port     ( alu_bus  )
    );

    mul_unit #(
        .DATA_W   ( DATA_W   ),
        .ID_W     ( ID_W     )
    ) mul_i (
        .clk_i    ( clk_i    ),
        .arst_n_i ( arst_n_i ),
        .port     ( mul_bus  )
    );

endmodule

`default_nettype wire

// ==== dv/unit_mux_checker.sv ====
// Concurrent assertions on the result output of the multiplexer top level
// Reset idle state and hold of a stalled result

`default_nettype none

module unit_mux_checker #(
    parameter int unsigned DATA_W = 32,
    parameter int unsigned ID_W   = 3
) (
    input logic              clk_i,
    input logic              arst_n_i,
    input logic              out_valid_o,
    input logic              out_ready_i,
    input logic [ID_W-1:0]   out_id_o,
    input logic [DATA_W-1:0] out_result_o
);
    timeunit 1ns;
    timeprecision 1ps;

    int unsigned fail_count;

    initial fail_count = 0;

    reset_idle_a: assert property (@(posedge clk_i) !arst_n_i |-> !out_valid_o)
        else begin
            $error("out_valid_o is high while reset is asserted");
            fail_count++;
        end

    // First edge after reset release
    reset_exit_a: assert property (@(posedge clk_i) $rose(arst_n_i) |-> !out_valid_o)
        else begin
            $error("out_valid_o is high on the first cycle after reset");
            fail_count++;
        end

    // A result that is not taken stays on the port unchanged
    out_hold_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        out_valid_o && !out_ready_i |=>
            out_valid_o && $stable(out_id_o) && $stable(out_result_o))
        else begin
            $error("stalled result changed or was dropped before out_ready_i");
            fail_count++;
        end

endmodule

`default_nettype wire

// ==== dv/unit_mux_tb.sv ====
// Testbench for the in-order result multiplexer
// Directed opcode checks, random mix under random backpressure, stall and drain

`default_nettype none

module unit_mux_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import vmux_pkg::*;

    localparam int unsigned DATA_W      = 32;
    localparam int unsigned ID_W        = 3;
    localparam int unsigned QUEUE_DEPTH = 4;
    localparam int          TIMEOUT     = 10 * (DATA_W + 4);

    logic              clk_i;
    logic              arst_n_i;
    logic              in_valid_i;
    logic              in_ready_o;
    logic [ID_W-1:0]   in_id_i;
    op_e               in_op_i;
    logic [DATA_W-1:0] in_a_i;
    logic [DATA_W-1:0] in_b_i;
    logic              out_valid_o;
    logic              out_ready_i;
    logic [ID_W-1:0]   out_id_o;
    logic [DATA_W-1:0] out_result_o;

    logic [31:0]       lcg_state;
    logic              in_fire;
    logic [ID_W-1:0]   next_id;
    logic [ID_W-1:0]   exp_id;
    logic [DATA_W-1:0] exp_res;
    logic [ID_W-1:0]   exp_id_q [$];
    logic [DATA_W-1:0] exp_res_q [$];
    string             test_name;

    unit_mux_top #(
        .DATA_W       ( DATA_W       ),
        .ID_W         ( ID_W         ),
        .QUEUE_DEPTH  ( QUEUE_DEPTH  )
    ) unit_mux_top_i (
        .clk_i        ( clk_i        ),
        .arst_n_i     ( arst_n_i     ),
        .in_valid_i   ( in_valid_i   ),
        .in_ready_o   ( in_ready_o   ),
        .in_id_i      ( in_id_i      ),
        .in_op_i      ( in_op_i      ),
        .in_a_i       ( in_a_i       ),
        .in_b_i       ( in_b_i       ),
        .out_valid_o  ( out_valid_o  ),
        .out_ready_i  ( out_ready_i  ),
        .out_id_o     ( out_id_o     ),
        .out_result_o ( out_result_o )
    );

    bind unit_mux_top unit_mux_checker #(.DATA_W(DATA_W), .ID_W(ID_W)) checker_i (
        .clk_i        ( clk_i        ),
        .arst_n_i     ( arst_n_i     ),
        .out_valid_o  ( out_valid_o  ),
        .out_ready_i  ( out_ready_i  ),
        .out_id_o     ( out_id_o     ),
        .out_result_o ( out_result_o )
    );

    always #20 clk_i = ~clk_i;

    // ------------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------------
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic logic [DATA_W-1:0] expected_result(op_e op, logic [DATA_W-1:0] a,
                                                          logic [DATA_W-1:0] b);
        logic [2*DATA_W-1:0] prod;
        prod = {{DATA_W{1'b0}}, a} * {{DATA_W{1'b0}}, b};
        case (op)
            OP_ADD:   return a + b;
            OP_SUB:   return a - b;
            OP_AND:   return a & b;
            OP_XOR:   return a ^ b;
            OP_MUL:   return prod[DATA_W-1:0];
            OP_MULHU: return prod[2*DATA_W-1:DATA_W];
            default:  return '0;
        endcase
    endfunction

    task automatic stop_on_error(input string line);
        $display("%s", line);
        $display("Some tests failed");
        $fatal(1, "stopping at the first error");
    endtask

    // Starts and ends on a falling edge so issues can go back to back
    task automatic issue_one(input op_e op, input logic [DATA_W-1:0] a,
                             input logic [DATA_W-1:0] b);
        int waited;
        waited     = 0;
        in_valid_i = 1'b1;
        in_id_i    = next_id;
        in_op_i    = op;
        in_a_i     = a;
        in_b_i     = b;
        do begin
            @(negedge clk_i);
            waited++;
        end while (!in_fire && waited < TIMEOUT);
        assert (in_fire) else stop_on_error("an instruction was never accepted by the DUT");
        next_id++;
        in_valid_i = 1'b0;
    endtask

    task automatic run_random(input int cycles, input int unsigned ready_pct);
        repeat (cycles) begin
            if (!in_valid_i) begin
                in_valid_i = ((lcg_next() >> 16) % 32'd4) != 32'd0;
                in_id_i    = next_id;
                in_op_i    = op_e'(3'((lcg_next() >> 16) % 32'd6));
                in_a_i     = DATA_W'(lcg_next());
                in_b_i     = DATA_W'(lcg_next());
            end
            out_ready_i = ((lcg_next() >> 16) % 32'd100) < ready_pct;
            @(negedge clk_i);
            if (in_fire) begin
                next_id++;
                in_valid_i = 1'b0;
            end
            assert (exp_id_q.size() <= QUEUE_DEPTH)
                else stop_on_error("more instructions in flight than the order queue holds");
        end
    endtask

    // Finishes a pending input, then waits until every result is out
    task automatic drain();
        int waited;
        waited      = 0;
        out_ready_i = 1'b1;
        while ((in_valid_i || exp_id_q.size() != 0) && waited < TIMEOUT) begin
            @(negedge clk_i);
            waited++;
            if (in_fire) begin
                next_id++;
                in_valid_i = 1'b0;
            end
        end
        assert (!in_valid_i && exp_id_q.size() == 0)
            else stop_on_error("results did not drain before the timeout");
    endtask

    // ------------------------------------------------------------------------
    // Reference model updated on every transfer
    // ------------------------------------------------------------------------
    always @(posedge clk_i) begin
        in_fire = arst_n_i && in_valid_i && in_ready_o;
        if (arst_n_i && out_valid_o && out_ready_i) begin
            assert (exp_id_q.size() != 0)
                else stop_on_error("a result came out with no instruction outstanding");
            exp_id  = exp_id_q.pop_front();
            exp_res = exp_res_q.pop_front();
            assert (out_id_o == exp_id)
                else stop_on_error($sformatf("FAILED %s: id expected %0h actual %0h",
                                             test_name, exp_id, out_id_o));
            assert (out_result_o == exp_res)
                else stop_on_error($sformatf("FAILED %s: result expected %0h actual %0h",
                                             test_name, exp_res, out_result_o));
        end
        if (in_fire) begin
            exp_id_q.push_back(in_id_i);
            exp_res_q.push_back(expected_result(in_op_i, in_a_i, in_b_i));
        end
    end

    initial begin
        clk_i       = 1'b0;
        arst_n_i    = 1'b0;
        in_valid_i  = 1'b0;
        in_id_i     = '0;
        in_op_i     = OP_ADD;
        in_a_i      = '0;
        in_b_i      = '0;
        out_ready_i = 1'b0;
        lcg_state   = 32'd39;
        in_fire     = 1'b0;
        next_id     = '0;
        test_name   = "reset";
        repeat (10) @(negedge clk_i);
        arst_n_i = 1'b1;
        @(negedge clk_i);
        assert (in_ready_o == 1'b1)
            else stop_on_error($sformatf("FAILED %s: in_ready_o expected 1 actual %0b",
                                         test_name, in_ready_o));
        assert (out_valid_o == 1'b0)
            else stop_on_error($sformatf("FAILED %s: out_valid_o expected 0 actual %0b",
                                         test_name, out_valid_o));

        test_name   = "directed_ops";
        out_ready_i = 1'b1;
        issue_one(OP_ADD, '1, DATA_W'(1));
        issue_one(OP_SUB, DATA_W'(3), DATA_W'(5));
        issue_one(OP_AND, DATA_W'(32'hf0f0_a5a5), DATA_W'(32'h0ff0_ffff));
        issue_one(OP_XOR, DATA_W'(32'h1234_5678), DATA_W'(32'hffff_0000));
        issue_one(OP_MUL, '1, '1);
        issue_one(OP_MULHU, '1, '1);
        issue_one(OP_MULHU, DATA_W'(32'h8000_0001), DATA_W'(32'h0001_0003));
        // ALU op right behind a multiply must still wait its turn
        issue_one(OP_MUL, DATA_W'(32'h0000_1234), DATA_W'(32'h0000_5678));
        issue_one(OP_ADD, DATA_W'(7), DATA_W'(9));
        drain();

        test_name = "random_mix";
        run_random(2000, 70);
        drain();

        test_name = "stall_drain";
        run_random(4 * DATA_W, 0);
        drain();

        if (unit_mux_top_i.checker_i.fail_count == 0) begin
            $display("All tests passed");
            $finish;
        end else begin
            $display("Some tests failed");
            $fatal(1, "output checker assertions failed");
        end
    end

endmodule

`default_nettype wire

// ==== sources.f ====
src/vmux_pkg.sv
src/unit_if.sv
src/unit_order_queue.sv
src/unit_dispatch.sv
src/alu_unit.sv
src/mul_unit.sv
src/unit_mux_top.sv
dv/unit_mux_checker.sv
dv/unit_mux_tb.sv

// ==== Makefile ====
TOP := unit_mux_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) -o $(TOP)

run: build
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed"

lint:
	verilator --lint-only -Wall --timing -f sources.f --top-module unit_mux_top

clean:
	rm -rf obj_dir
